//--- tlul_mon_pkg.sv
// TL-UL protocol monitor shared definitions
// field widths, opcode encodings, violation codes and fault machine states
package tlul_mon_pkg;

  ////////////////////////////////////////
  // bus field types
  ////////////////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [3:0]  mask_t;
  // log2 of the byte count
  typedef logic [1:0]  size_t;
  typedef logic [2:0]  opcode_t;
  // reserved, must be zero on both channels
  typedef logic [2:0]  param_t;

  // request opcodes (A channel)
  localparam opcode_t OP_PUT_FULL    = 3'd0;
  localparam opcode_t OP_PUT_PARTIAL = 3'd1;
  localparam opcode_t OP_GET         = 3'd4;
  // response opcodes (D channel)
  localparam opcode_t OP_ACK         = 3'd0;
  localparam opcode_t OP_ACK_DATA    = 3'd1;

  ////////////////////////////////////////
  // violation reporting
  ////////////////////////////////////////

  // zero means no violation, lower code has priority
  typedef logic [3:0] viol_t;

  localparam viol_t V_NONE        = 4'd0;
  localparam viol_t V_OPCODE      = 4'd1;
  localparam viol_t V_A_PARAM     = 4'd2;
  localparam viol_t V_SIZE        = 4'd3;
  localparam viol_t V_MASK_SIZE   = 4'd4;
  localparam viol_t V_ALIGN       = 4'd5;
  localparam viol_t V_MASK_CONTIG = 4'd6;
  localparam viol_t V_SRC_BUSY    = 4'd7;
  localparam viol_t V_NO_REQ      = 4'd8;
  localparam viol_t V_RSP_OPCODE  = 4'd9;
  localparam viol_t V_RSP_SIZE    = 4'd10;
  localparam viol_t V_D_PARAM     = 4'd11;
  localparam viol_t V_TIMEOUT     = 4'd12;

  // saturating count of cycles with a violation
  typedef logic [7:0] errcnt_t;

  typedef enum logic {
    MON_RUN,
    MON_FAULT
  } mon_state_e;

endpackage

//--- tlul_req_check.sv
// TL-UL request checker
// legality rules on an accepted A-channel beat, lowest failing code reported
`timescale 1ns/10ps
module tlul_req_check (
  input  logic                  a_fire_i,
  input  tlul_mon_pkg::opcode_t a_opcode_i,
  input  tlul_mon_pkg::param_t  a_param_i,
  input  tlul_mon_pkg::size_t   a_size_i,
  input  tlul_mon_pkg::addr_t   a_address_i,
  input  tlul_mon_pkg::mask_t   a_mask_i,
  input  logic                  src_busy_i,
  output tlul_mon_pkg::viol_t   req_viol_o
);
  import tlul_mon_pkg::*;

  // number of set mask bits, 0 to 4
  logic [2:0] mask_ones;
  // bytes covered by a_size, 8 for the illegal size 3
  logic [3:0] size_bytes;
  // a one marks each 0/1 transition inside the mask
  mask_t      mask_edges;
  logic [2:0] edge_cnt;
  logic       size_mask_ok;
  logic       align_ok;
  logic       contig_ok;

  assign mask_ones  = 3'($countones(a_mask_i));
  assign size_bytes = 4'd1 << a_size_i;

  // full writes need an exact byte count, reads and partial writes an upper bound
  assign size_mask_ok = (a_opcode_i == OP_PUT_FULL) ? ({1'b0, mask_ones} == size_bytes)
                                                     : ({1'b0, mask_ones} <= size_bytes);

  // low address bits below the access size must be zero
  assign align_ok = ((a_address_i[3:0] & (size_bytes - 4'd1)) == 4'd0);

  // a contiguous run has at most two edges against its shifted copy
  assign mask_edges = a_mask_i ^ {a_mask_i[2:0], 1'b0};
  assign edge_cnt   = 3'($countones(mask_edges));
  assign contig_ok  = (a_opcode_i == OP_PUT_PARTIAL) || (edge_cnt <= 3'd2);

  // rules in code order, first failure wins
  always_comb begin
    req_viol_o = V_NONE;
    if (a_fire_i) begin
      if (!(a_opcode_i inside {OP_PUT_FULL, OP_PUT_PARTIAL, OP_GET})) begin
        req_viol_o = V_OPCODE;
      end else if (a_param_i != '0) begin
        req_viol_o = V_A_PARAM;
      end else if (a_size_i > 2'd2) begin
        req_viol_o = V_SIZE;
      end else if (!size_mask_ok) begin
        req_viol_o = V_MASK_SIZE;
      end else if (!align_ok) begin
        req_viol_o = V_ALIGN;
      end else if (!contig_ok) begin
        req_viol_o = V_MASK_CONTIG;
      end else if (src_busy_i) begin
        // uses the registered table, a same-cycle response does not free it
        req_viol_o = V_SRC_BUSY;
      end
    end
  end

endmodule

//--- tlul_pend_table.sv
// TL-UL pending request table
// one entry per source ID with pending bit, opcode and size,
// plus the count of outstanding requests
`timescale 1ns/10ps
module tlul_pend_table #(
  parameter int SrcW = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  a_fire_i,
  input  logic [SrcW-1:0]       a_source_i,
  input  tlul_mon_pkg::opcode_t a_opcode_i,
  input  tlul_mon_pkg::size_t   a_size_i,
  input  logic                  d_fire_i,
  input  logic [SrcW-1:0]       d_source_i,
  output logic                  a_busy_o,
  output logic                  d_pend_o,
  output tlul_mon_pkg::opcode_t d_opcode_o,
  output tlul_mon_pkg::size_t   d_size_o,
  output logic [SrcW:0]         outstanding_o
);
  import tlul_mon_pkg::*;

  localparam int Entries = 2 ** SrcW;

  logic [Entries-1:0] pend_q;
  opcode_t            op_q   [Entries];
  size_t              size_q [Entries];

  ////////////////////////////////////////
  // table update
  ////////////////////////////////////////

  // clear first, then set, so a set on the same source wins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= '0;
    end else begin
      if (d_fire_i) begin
        pend_q[d_source_i] <= 1'b0;
      end
      if (a_fire_i) begin
        pend_q[a_source_i] <= 1'b1;
      end
    end
  end

  // opcode and size are only read while the pending bit is set
  always_ff @(posedge clk_i) begin
    if (a_fire_i) begin
      op_q[a_source_i]   <= a_opcode_i;
      size_q[a_source_i] <= a_size_i;
    end
  end

  ////////////////////////////////////////
  // lookups and outstanding count
  ////////////////////////////////////////

  assign a_busy_o   = pend_q[a_source_i];
  assign d_pend_o   = pend_q[d_source_i];
  assign d_opcode_o = op_q[d_source_i];
  assign d_size_o   = size_q[d_source_i];

  // one extra bit so a full table fits
  always_comb begin
    outstanding_o = '0;
    for (int i = 0; i < Entries; i++) begin
      outstanding_o = outstanding_o + (SrcW + 1)'(pend_q[i]);
    end
  end

endmodule

//--- tlul_rsp_check.sv
// TL-UL response checker
// compares an accepted D-channel beat with the pending entry of its source
`timescale 1ns/10ps
module tlul_rsp_check (
  input  logic                  d_fire_i,
  input  tlul_mon_pkg::opcode_t d_opcode_i,
  input  tlul_mon_pkg::param_t  d_param_i,
  input  tlul_mon_pkg::size_t   d_size_i,
  input  logic                  d_pend_i,
  input  tlul_mon_pkg::opcode_t pend_opcode_i,
  input  tlul_mon_pkg::size_t   pend_size_i,
  output tlul_mon_pkg::viol_t   rsp_viol_o
);
  import tlul_mon_pkg::*;

  // reads return data, both write flavours get a plain ack
  opcode_t exp_opcode;

  assign exp_opcode = (pend_opcode_i == OP_GET) ? OP_ACK_DATA : OP_ACK;

  // rules in code order, first failure wins
  always_comb begin
    rsp_viol_o = V_NONE;
    if (d_fire_i) begin
      if (!d_pend_i) begin
        // nothing outstanding on this source
        rsp_viol_o = V_NO_REQ;
      end else if (d_opcode_i != exp_opcode) begin
        rsp_viol_o = V_RSP_OPCODE;
      end else if (d_size_i != pend_size_i) begin
        rsp_viol_o = V_RSP_SIZE;
      end else if (d_param_i != '0) begin
        rsp_viol_o = V_D_PARAM;
      end
    end
  end

endmodule

//--- tlul_rsp_timer.sv
// TL-UL response watchdog
// counts cycles without an accepted response while requests are outstanding,
// pulses timeout_o for one cycle after TimeoutCycles such cycles
`timescale 1ns/10ps
module tlul_rsp_timer #(
  parameter int SrcW          = 4,
  parameter int TimeoutCycles = 64
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic [SrcW:0] outstanding_i,
  input  logic          d_fire_i,
  output logic          timeout_o
);

  localparam int CntW = $clog2(TimeoutCycles + 1);
  // last count value before the pulse
  localparam logic [CntW-1:0] CntLast = CntW'(TimeoutCycles - 1);

  logic [CntW-1:0] cnt_q;
  logic            stall;
  logic            timeout_q;

  // waiting on a response and none arrives this cycle
  assign stall = (outstanding_i != '0) && !d_fire_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      timeout_q <= 1'b0;
    end else if (!stall) begin
      // any response or an empty table restarts the count
      cnt_q     <= '0;
      timeout_q <= 1'b0;
    end else if (cnt_q == CntLast) begin
      // limit reached, pulse and start over
      cnt_q     <= '0;
      timeout_q <= 1'b1;
    end else begin
      cnt_q     <= cnt_q + 1'b1;
      timeout_q <= 1'b0;
    end
  end

  assign timeout_o = timeout_q;

endmodule

//--- tlul_err_fsm.sv
// TL-UL monitor fault machine
// latches the first violation code until clear and counts violation cycles
`timescale 1ns/10ps
module tlul_err_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  tlul_mon_pkg::viol_t   req_viol_i,
  input  tlul_mon_pkg::viol_t   rsp_viol_i,
  input  logic                  timeout_i,
  input  logic                  clear_i,
  output logic                  err_o,
  output tlul_mon_pkg::viol_t   err_code_o,
  output tlul_mon_pkg::errcnt_t err_cnt_o
);
  import tlul_mon_pkg::*;

  mon_state_e state_q;
  viol_t      code_q;
  errcnt_t    cnt_q;
  viol_t      tmo_code;
  viol_t      lo_code;
  viol_t      sel_code;
  logic       viol;

  ////////////////////////////////////////
  // code selection
  ////////////////////////////////////////

  assign tmo_code = timeout_i ? V_TIMEOUT : V_NONE;

  // lowest nonzero of the three sources
  always_comb begin
    lo_code = req_viol_i;
    if (lo_code == V_NONE || (rsp_viol_i != V_NONE && rsp_viol_i < lo_code)) begin
      lo_code = rsp_viol_i;
    end
    sel_code = lo_code;
    if (sel_code == V_NONE || (tmo_code != V_NONE && tmo_code < sel_code)) begin
      sel_code = tmo_code;
    end
  end

  assign viol = (sel_code != V_NONE);

  ////////////////////////////////////////
  // sticky state, code and counter
  ////////////////////////////////////////

  // a new violation beats clear_i in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MON_RUN;
      code_q  <= V_NONE;
      cnt_q   <= '0;
    end else begin
      if (viol) begin
        state_q <= MON_FAULT;
        // only the first code is kept while faulted
        if (state_q == MON_RUN || clear_i) begin
          code_q <= sel_code;
        end
      end else if (clear_i) begin
        state_q <= MON_RUN;
        code_q  <= V_NONE;
      end
      if (clear_i) begin
        cnt_q <= viol ? errcnt_t'(1) : '0;
      end else if (viol && cnt_q != '1) begin
        // saturates at all ones
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign err_o      = (state_q == MON_FAULT);
  assign err_code_o = code_q;
  assign err_cnt_o  = cnt_q;

endmodule

//--- tlul_proto_mon.sv
// TL-UL device port protocol monitor
// passive checker on the A and D channels with sticky fault code,
// violation counter and response watchdog
`timescale 1ns/10ps
module tlul_proto_mon #(
  parameter int SrcW          = 4,
  parameter int TimeoutCycles = 64
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // A channel
  input  logic                  a_valid_i,
  input  logic                  a_ready_i,
  input  tlul_mon_pkg::opcode_t a_opcode_i,
  input  tlul_mon_pkg::param_t  a_param_i,
  input  tlul_mon_pkg::size_t   a_size_i,
  input  logic [SrcW-1:0]       a_source_i,
  input  tlul_mon_pkg::addr_t   a_address_i,
  input  tlul_mon_pkg::mask_t   a_mask_i,
  // D channel
  input  logic                  d_valid_i,
  input  logic                  d_ready_i,
  input  tlul_mon_pkg::opcode_t d_opcode_i,
  input  tlul_mon_pkg::param_t  d_param_i,
  input  tlul_mon_pkg::size_t   d_size_i,
  input  logic [SrcW-1:0]       d_source_i,
  // status
  input  logic                  clear_i,
  output logic                  err_o,
  output tlul_mon_pkg::viol_t   err_code_o,
  output tlul_mon_pkg::errcnt_t err_cnt_o,
  output logic [SrcW:0]         outstanding_o
);
  import tlul_mon_pkg::*;

  logic    a_fire;
  logic    d_fire;
  logic    a_busy;
  logic    d_pend;
  opcode_t pend_opcode;
  size_t   pend_size;
  viol_t   req_viol;
  viol_t   rsp_viol;
  logic    timeout;

  // only accepted beats are checked
  assign a_fire = a_valid_i & a_ready_i;
  assign d_fire = d_valid_i & d_ready_i;

  tlul_req_check u_req_check (
    .a_fire_i    (a_fire),
    .a_opcode_i  (a_opcode_i),
    .a_param_i   (a_param_i),
    .a_size_i    (a_size_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .src_busy_i  (a_busy),
    .req_viol_o  (req_viol)
  );

  // every accepted request is tracked, legal or not
  tlul_pend_table #(
    .SrcW (SrcW)
  ) u_pend_table (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .a_fire_i      (a_fire),
    .a_source_i    (a_source_i),
    .a_opcode_i    (a_opcode_i),
    .a_size_i      (a_size_i),
    .d_fire_i      (d_fire),
    .d_source_i    (d_source_i),
    .a_busy_o      (a_busy),
    .d_pend_o      (d_pend),
    .d_opcode_o    (pend_opcode),
    .d_size_o      (pend_size),
    .outstanding_o (outstanding_o)
  );

  tlul_rsp_check u_rsp_check (
    .d_fire_i      (d_fire),
    .d_opcode_i    (d_opcode_i),
    .d_param_i     (d_param_i),
    .d_size_i      (d_size_i),
    .d_pend_i      (d_pend),
    .pend_opcode_i (pend_opcode),
    .pend_size_i   (pend_size),
    .rsp_viol_o    (rsp_viol)
  );

  tlul_rsp_timer #(
    .SrcW          (SrcW),
    .TimeoutCycles (TimeoutCycles)
  ) u_rsp_timer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .outstanding_i (outstanding_o),
    .d_fire_i      (d_fire),
    .timeout_o     (timeout)
  );

  tlul_err_fsm u_err_fsm (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_viol_i (req_viol),
    .rsp_viol_i (rsp_viol),
    .timeout_i  (timeout),
    .clear_i    (clear_i),
    .err_o      (err_o),
    .err_code_o (err_code_o),
    .err_cnt_o  (err_cnt_o)
  );

endmodule

//--- tlul_proto_mon_props.sv
// TL-UL monitor status properties
// sanity rules on the fault outputs and the outstanding count
`timescale 1ns/10ps
module tlul_proto_mon_props #(
  parameter int SrcW = 4
) (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                clear_i,
  input logic                err_o,
  input tlul_mon_pkg::viol_t err_code_o,
  input logic [SrcW:0]       outstanding_o
);

  // number of failed assertions
  int assert_fails = 0;

  // the sticky fault only drops after a clear request
  a_err_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(err_o) |-> $past(clear_i))
    else begin
      assert_fails++;
      $error("err_o fell without clear_i in the previous cycle");
    end

  // a raised fault always carries a code
  a_err_code: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_o |-> (err_code_o != '0))
    else begin
      assert_fails++;
      $error("err_o high with a zero err_code_o");
    end

  // table cannot hold more than one request per source
  a_out_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    int'(outstanding_o) <= 2 ** SrcW)
    else begin
      assert_fails++;
      $error("outstanding_o above the number of sources");
    end

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset generator
// free running clock, active low reset held for a fixed number of cycles
`timescale 1ns/10ps
module tb_clk_gen #(
  parameter int PeriodNs  = 40,
  parameter int RstCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- tb_tlul_proto_mon.sv
// testbench for the TL-UL protocol monitor
// random legal and corrupted traffic against a cycle model of the monitor rules
`timescale 1ns/10ps
module tb_tlul_proto_mon;
  import tlul_mon_pkg::*;

  localparam int SrcW        = 4;
  localparam int NumSrc      = 2 ** SrcW;
  localparam int TmoCycles   = 32;
  localparam int RstCycles   = 16;
  localparam int P1Cycles    = 1500;
  localparam int P2Trials    = 60;
  localparam int P3Trials    = 40;
  // drain, clear and up to three beats per trial
  localparam int TrialCycles = NumSrc + 5;
  localparam int P4Cycles    = NumSrc + TmoCycles + 10;
  localparam int P5Cycles    = NumSrc + 310;
  localparam int CycLimit    = 2 * (RstCycles + P1Cycles + (P2Trials + P3Trials) * TrialCycles
                                    + P4Cycles + P5Cycles);

  logic clk;
  logic rst_n;
  logic a_valid, a_ready, d_valid, d_ready, clear;
  opcode_t a_opcode, d_opcode;
  param_t a_param, d_param;
  size_t a_size, d_size;
  logic [SrcW-1:0] a_source, d_source;
  addr_t a_address;
  mask_t a_mask;
  logic err;
  viol_t err_code;
  errcnt_t err_cnt;
  logic [SrcW:0] outstanding;

  // reference model state
  logic    m_pend [NumSrc];
  opcode_t m_op   [NumSrc];
  size_t   m_size [NumSrc];
  int      m_out, m_tcnt, m_cnt;
  logic    m_tmo, m_err;
  viol_t   m_code;

  logic [31:0] lfsr_q = 32'h6796d059;
  int cyc_cnt = 0;

  tb_clk_gen #(.PeriodNs(40), .RstCycles(RstCycles)) u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  tlul_proto_mon #(.SrcW(SrcW), .TimeoutCycles(TmoCycles)) u_dut (
    .clk_i(clk), .rst_ni(rst_n),
    .a_valid_i(a_valid), .a_ready_i(a_ready), .a_opcode_i(a_opcode), .a_param_i(a_param),
    .a_size_i(a_size), .a_source_i(a_source), .a_address_i(a_address), .a_mask_i(a_mask),
    .d_valid_i(d_valid), .d_ready_i(d_ready), .d_opcode_i(d_opcode), .d_param_i(d_param),
    .d_size_i(d_size), .d_source_i(d_source),
    .clear_i(clear), .err_o(err), .err_code_o(err_code), .err_cnt_o(err_cnt),
    .outstanding_o(outstanding)
  );

  bind tlul_proto_mon tlul_proto_mon_props #(.SrcW(SrcW)) u_props (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i), .err_o(err_o),
    .err_code_o(err_code_o), .outstanding_o(outstanding_o)
  );

  ////////////////////////////////////////
  // random numbers and checking
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  // one lfsr step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= CycLimit) begin
      $display("timeout: the run did not finish within %0d cycles", CycLimit);
      $display("=== FAIL ===");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic is_contig(input mask_t mask);
    mask_t m;
    m = mask;
    if (m == '0) return 1'b1;
    while (!m[0]) m = m >> 1;
    return (m & (m + 4'd1)) == '0;
  endfunction

  function automatic viol_t req_code();
    int ones;
    int nbytes;
    ones = 0;
    for (int i = 0; i < 4; i++) ones += int'(a_mask[i]);
    nbytes = 1 << a_size;
    if (!(a_opcode inside {OP_PUT_FULL, OP_PUT_PARTIAL, OP_GET})) return V_OPCODE;
    if (a_param != '0) return V_A_PARAM;
    if (a_size > 2'd2) return V_SIZE;
    if ((a_opcode == OP_PUT_FULL) ? (ones != nbytes) : (ones > nbytes)) return V_MASK_SIZE;
    if (int'(a_address[3:0]) % nbytes != 0) return V_ALIGN;
    if (a_opcode != OP_PUT_PARTIAL && !is_contig(a_mask)) return V_MASK_CONTIG;
    if (m_pend[a_source]) return V_SRC_BUSY;
    return V_NONE;
  endfunction

  function automatic viol_t rsp_code();
    opcode_t exp_op;
    if (!m_pend[d_source]) return V_NO_REQ;
    exp_op = (m_op[d_source] == OP_GET) ? OP_ACK_DATA : OP_ACK;
    if (d_opcode != exp_op) return V_RSP_OPCODE;
    if (d_size != m_size[d_source]) return V_RSP_SIZE;
    if (d_param != '0) return V_D_PARAM;
    return V_NONE;
  endfunction

  function automatic viol_t lowest(input viol_t x, input viol_t y);
    if (x == V_NONE) return y;
    if (y == V_NONE) return x;
    return (x < y) ? x : y;
  endfunction

  // one clock edge of the monitor, from the inputs held across it
  task automatic model_step();
    logic a_fire;
    logic d_fire;
    logic stall;
    viol_t sel;
    a_fire = a_valid && a_ready;
    d_fire = d_valid && d_ready;
    sel = lowest(a_fire ? req_code() : V_NONE, d_fire ? rsp_code() : V_NONE);
    sel = lowest(sel, m_tmo ? V_TIMEOUT : V_NONE);
    // first code sticks and a new fault beats clear
    if (sel != V_NONE) begin
      if (!m_err || clear) m_code = sel;
      m_err = 1'b1;
    end else if (clear) begin
      m_err = 1'b0;
      m_code = V_NONE;
    end
    if (clear) m_cnt = (sel != V_NONE) ? 1 : 0;
    else if (sel != V_NONE && m_cnt < 255) m_cnt++;
    // watchdog on the registered outstanding count
    stall = (m_out != 0) && !d_fire;
    if (stall && m_tcnt == TmoCycles - 1) begin
      m_tcnt = 0;
      m_tmo = 1'b1;
    end else begin
      m_tcnt = stall ? m_tcnt + 1 : 0;
      m_tmo = 1'b0;
    end
    // set after clear on the same source
    if (d_fire) m_pend[d_source] = 1'b0;
    if (a_fire) begin
      m_pend[a_source] = 1'b1;
      m_op[a_source] = a_opcode;
      m_size[a_source] = a_size;
    end
    m_out = 0;
    for (int i = 0; i < NumSrc; i++) m_out += int'(m_pend[i]);
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // outputs sampled 1 ns after the edge, inputs changed 1 ns later
  task automatic tick();
    @(posedge clk);
    #1;
    model_step();
    check_eq(err, m_err, "err_o");
    check_eq(err_code, m_code, "err_code_o");
    check_eq(err_cnt, m_cnt, "err_cnt_o");
    check_eq(outstanding, m_out, "outstanding_o");
    #1;
  endtask

  task automatic set_idle();
    a_valid = 0;
    a_ready = 0;
    a_opcode = '0;
    a_param = '0;
    a_size = '0;
    a_source = '0;
    a_address = '0;
    a_mask = '0;
    d_valid = 0;
    d_ready = 0;
    d_opcode = '0;
    d_param = '0;
    d_size = '0;
    d_source = '0;
    clear = 0;
  endtask

  // first source from a random start whose pending bit equals want
  function automatic int pick_src(input logic want);
    int start;
    start = int'(rand_bits(SrcW));
    for (int i = 0; i < NumSrc; i++) begin
      if (m_pend[(start + i) % NumSrc] == want) return (start + i) % NumSrc;
    end
    return -1;
  endfunction

  task automatic make_legal(input int src);
    int nbytes;
    mask_t lanes;
    a_valid = 1;
    a_ready = 1;
    a_source = src;
    a_param = '0;
    case (rand_bits(2))
      0: a_opcode = OP_PUT_FULL;
      1: a_opcode = OP_PUT_PARTIAL;
      default: a_opcode = OP_GET;
    endcase
    a_size = size_t'(rand_bits(2) % 3);
    nbytes = 1 << a_size;
    a_address = rand_bits(32);
    a_address = a_address & ~addr_t'(nbytes - 1);
    lanes = mask_t'(((1 << nbytes) - 1) << a_address[1:0]);
    a_mask = (a_opcode == OP_PUT_PARTIAL) ? (lanes & mask_t'(rand_bits(4))) : lanes;
  endtask

  task automatic make_rsp(input int src);
    d_valid = 1;
    d_ready = 1;
    d_source = src;
    d_param = '0;
    d_opcode = (m_op[src] == OP_GET) ? OP_ACK_DATA : OP_ACK;
    d_size = m_size[src];
  endtask

  task automatic no_req_rsp(input int src);
    d_valid = 1;
    d_ready = 1;
    d_source = src;
    d_opcode = OP_ACK;
    d_param = '0;
    d_size = '0;
  endtask

  // answer every pending source correctly
  task automatic drain();
    for (int i = 0; i < NumSrc; i++) begin
      if (m_pend[i]) begin
        set_idle();
        make_rsp(i);
        tick();
      end
    end
    set_idle();
  endtask

  task automatic clear_mon();
    set_idle();
    clear = 1;
    tick();
    clear = 0;
    check_eq(err, 0, "err_o after clear");
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int s;
    int p;
    int kind;
    int waited;
    logic [2:0] r3;
    viol_t exp;
    set_idle();
    for (int i = 0; i < NumSrc; i++) begin
      m_pend[i] = 0;
      m_op[i] = '0;
      m_size[i] = '0;
    end
    m_out = 0;
    m_tcnt = 0;
    m_cnt = 0;
    m_tmo = 0;
    m_err = 0;
    m_code = V_NONE;
    @(posedge rst_n);
    @(posedge clk);
    #2;

    // legal traffic with random stalls on both channels
    for (int c = 0; c < P1Cycles; c++) begin
      set_idle();
      s = pick_src(1'b0);
      if (rand_bits(1) && s >= 0) begin
        make_legal(s);
        a_ready = (rand_bits(2) != 0);
      end
      p = pick_src(1'b1);
      if (rand_bits(1) && p >= 0) begin
        make_rsp(p);
        d_ready = (rand_bits(2) != 0);
      end
      tick();
      check_eq(err, 0, "err_o during legal traffic");
    end

    // one corrupted field per request
    for (int t = 0; t < P2Trials; t++) begin
      kind = int'(rand_bits(3)) % 7;
      drain();
      clear_mon();
      s = int'(rand_bits(SrcW));
      make_legal(s);
      case (kind)
        0: begin
          r3 = 3'(rand_bits(3));
          if (r3 inside {3'd0, 3'd1, 3'd4}) r3 = r3 + 3'd2;
          a_opcode = r3;
        end
        1: a_param = param_t'(rand_bits(2)) + 3'd1;
        2: a_size = 2'd3;
        3: begin
          a_size = 2'd0;
          a_mask = 4'hf;
        end
        4: begin
          a_size = 2'd2;
          a_mask = 4'hf;
          a_address[0] = 1'b1;
        end
        5: begin
          a_opcode = OP_GET;
          a_size = 2'd2;
          a_address[1:0] = 2'b00;
          a_mask = rand_bits(1) ? 4'b1010 : 4'b1101;
        end
        default: begin
          // same source again while still pending
          tick();
          make_legal(s);
          // a same-cycle response to that source does not free it
          if (rand_bits(1)) make_rsp(s);
        end
      endcase
      tick();
      check_eq(err, 1, "err_o after corrupted request");
      check_eq(err_code, kind + 1, "code of corrupted request");
    end

    // bad responses, and a request and response fault together
    for (int t = 0; t < P3Trials; t++) begin
      kind = int'(rand_bits(3)) % 5;
      drain();
      clear_mon();
      s = int'(rand_bits(SrcW));
      case (kind)
        0: begin
          no_req_rsp(s);
          exp = V_NO_REQ;
        end
        4: begin
          make_legal(s);
          a_param = 3'd3;
          no_req_rsp((s + 1) % NumSrc);
          exp = V_A_PARAM;
        end
        default: begin
          make_legal(s);
          tick();
          set_idle();
          make_rsp(s);
          if (kind == 1) begin
            d_opcode[0] = ~d_opcode[0];
            exp = V_RSP_OPCODE;
          end else if (kind == 2) begin
            d_size = d_size + 2'd1;
            exp = V_RSP_SIZE;
          end else begin
            d_param = param_t'(rand_bits(2)) + 3'd1;
            exp = V_D_PARAM;
          end
        end
      endcase
      tick();
      check_eq(err_code, exp, "code of bad response");
    end

    // watchdog counted from the last accepted response
    drain();
    clear_mon();
    make_legal(3);
    tick();
    make_legal(9);
    tick();
    set_idle();
    make_rsp(3);
    tick();
    set_idle();
    waited = 0;
    while (!err && waited < TmoCycles + 4) begin
      tick();
      waited++;
    end
    check_eq(waited, TmoCycles + 1, "cycles from last response to timeout");
    check_eq(err_code, V_TIMEOUT, "timeout code");

    // first code kept while the counter saturates
    drain();
    clear_mon();
    no_req_rsp(0);
    tick();
    for (int k = 0; k < 300; k++) begin
      set_idle();
      make_legal(k % NumSrc);
      a_param = 3'd1;
      if (k > 0) make_rsp((k - 1) % NumSrc);
      tick();
    end
    set_idle();
    make_rsp(299 % NumSrc);
    tick();
    check_eq(err_code, V_NO_REQ, "first code kept");
    check_eq(err_cnt, 255, "saturated violation count");
    clear_mon();
    check_eq(err_code, V_NONE, "code after clear");
    check_eq(err_cnt, 0, "count after clear");

    if (u_dut.u_props.assert_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- src.f
tlul_mon_pkg.sv
tlul_req_check.sv
tlul_pend_table.sv
tlul_rsp_check.sv
tlul_rsp_timer.sv
tlul_err_fsm.sv
tlul_proto_mon.sv
tlul_proto_mon_props.sv
tb_clk_gen.sv
tb_tlul_proto_mon.sv
